// File: verilog/lsab_defines.svh
`ifndef LSAB_DEFINES_SVH
`define LSAB_DEFINES_SVH

// queue bank geometry
`define LSAB_NUM_QUEUES 4
`define LSAB_QSEL_W     2

// per-queue region, 64 slots but one always stays free
`define LSAB_PTR_W      6
`define LSAB_QUEUE_MAX  63

// payload
`define LSAB_DATA_W     32

// shared RAM, {qsel, ptr}
`define LSAB_MEM_ADDR_W 8

`endif

// File: verilog/lsab_queue_pkg.sv
`include "lsab_defines.svh"

package lsab_queue_pkg;

  typedef logic [`LSAB_DATA_W-1:0] lsab_word_t;

  // one lane per queue
  typedef logic [`LSAB_NUM_QUEUES-1:0][`LSAB_DATA_W-1:0] lsab_word_vec_t;

  typedef logic [`LSAB_QSEL_W-1:0] lsab_qsel_t;

  typedef logic [`LSAB_PTR_W-1:0] lsab_ptr_t;

  typedef logic [`LSAB_NUM_QUEUES-1:0] lsab_qmask_t;

  // strobe plus queue number, no ready
  typedef struct packed {
    logic       valid;
    lsab_qsel_t qsel;
  } lsab_req_t;

  typedef struct packed {
    lsab_ptr_t wr_ptr;
    lsab_ptr_t rd_ptr;
    logic      empty;
    logic      full;
    logic      push_ok; // combinational, push and not full
    logic      pop_ok;  // combinational, pop and not empty
  } lsab_qstate_t;

endpackage

// File: verilog/lsab_mem_pkg.sv
`include "lsab_defines.svh"

package lsab_mem_pkg;

  // write side of the shared RAM
  typedef struct packed {
    logic                        en;
    logic [`LSAB_MEM_ADDR_W-1:0] addr; // {qsel, wr_ptr}
    logic [`LSAB_DATA_W-1:0]     data;
  } lsab_mem_wr_t;

  // read side, data comes back through the capture register
  typedef struct packed {
    logic                        en;
    logic [`LSAB_MEM_ADDR_W-1:0] addr; // {qsel, rd_ptr}
  } lsab_mem_rd_t;

endpackage

// File: verilog/lsab_queue_ctrl.sv
`timescale 1ns/1ps
`include "lsab_defines.svh"

module lsab_queue_ctrl
  import lsab_queue_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,
  input  logic         push,
  input  logic         pop,
  output lsab_qstate_t state
);

  lsab_ptr_t wr_ptr;
  lsab_ptr_t rd_ptr;
  lsab_ptr_t len;
  logic      full;
  logic      empty;

  logic      push_ok;
  logic      pop_ok;
  lsab_ptr_t len_nxt;
  logic      full_nxt;
  logic      empty_nxt;

  assign push_ok = push & ~full;  // write to a full queue is dropped
  assign pop_ok  = pop & ~empty;  // read of an empty queue is ignored

  always_comb begin
    case ({pop_ok, push_ok})
      2'b10:   len_nxt = len - 1'b1;
      2'b01:   len_nxt = len + 1'b1;
      default: len_nxt = len; // both or neither
    endcase
  end

  // flags only move on a net change of length
  always_comb begin
    full_nxt  = full;
    empty_nxt = empty;
    if (push_ok && !pop_ok) begin
      if (len == lsab_ptr_t'(`LSAB_QUEUE_MAX - 1))
        full_nxt = 1'b1;
      if (len == '0)
        empty_nxt = 1'b0;
    end else if (pop_ok && !push_ok) begin
      if (len == lsab_ptr_t'(`LSAB_QUEUE_MAX))
        full_nxt = 1'b0;
      if (len == lsab_ptr_t'(1))
        empty_nxt = 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST) begin
      len   <= '0;
      full  <= 1'b0;
      empty <= 1'b1;
    end else begin
      len   <= len_nxt;
      full  <= full_nxt;
      empty <= empty_nxt;
    end
  end

  // pointers wrap inside the 64-word region
  always_ff @(posedge CLK) begin
    if (!RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop_ok)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_comb begin
    state         = '0;
    state.wr_ptr  = wr_ptr;
    state.rd_ptr  = rd_ptr;
    state.empty   = empty;
    state.full    = full;
    state.push_ok = push_ok;
    state.pop_ok  = pop_ok;
  end

endmodule

// File: verilog/lsab_port_mux.sv
`timescale 1ns/1ps
`include "lsab_defines.svh"

module lsab_port_mux
  import lsab_queue_pkg::*,
         lsab_mem_pkg::*;
(
  input  lsab_req_t      wr_req,
  input  lsab_req_t      rd_req,
  input  lsab_word_vec_t wr_data,
  input  lsab_qstate_t   qstate [`LSAB_NUM_QUEUES],
  output lsab_qmask_t    push,
  output lsab_qmask_t    pop,
  output lsab_mem_wr_t   mem_wr,
  output lsab_mem_rd_t   mem_rd
);

  lsab_qstate_t wr_q;
  lsab_qstate_t rd_q;
  lsab_word_t   wr_word;

  // one-hot request decode
  always_comb begin
    push = '0;
    if (wr_req.valid)
      push[wr_req.qsel] = 1'b1;
  end

  always_comb begin
    pop = '0;
    if (rd_req.valid)
      pop[rd_req.qsel] = 1'b1;
  end

  // state of the queue each port is addressing
  assign wr_q = qstate[wr_req.qsel];
  assign rd_q = qstate[rd_req.qsel];

  assign wr_word = wr_data[wr_req.qsel]; // lane of the target queue

  always_comb begin
    mem_wr      = '0;
    mem_wr.en   = wr_q.push_ok; // already gated by full
    mem_wr.addr = {wr_req.qsel, wr_q.wr_ptr};
    mem_wr.data = wr_word;
  end

  always_comb begin
    mem_rd      = '0;
    mem_rd.en   = rd_q.pop_ok; // already gated by empty
    mem_rd.addr = {rd_req.qsel, rd_q.rd_ptr};
  end

endmodule

// File: verilog/lsab_sram.sv
`timescale 1ns/1ps
`include "lsab_defines.svh"

module lsab_sram
  import lsab_queue_pkg::*,
         lsab_mem_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,
  input  lsab_mem_wr_t mem_wr,
  input  lsab_mem_rd_t mem_rd,
  output lsab_word_t   rd_data
);

  localparam int DEPTH = 1 << `LSAB_MEM_ADDR_W;

  lsab_word_t mem [DEPTH];
  lsab_word_t rd_word;
  logic       rd_pend;

  always_ff @(posedge CLK) begin
    if (mem_wr.en)
      mem[mem_wr.addr] <= mem_wr.data;
  end

  // a live entry is never the write slot, so no read/write collision
  always_ff @(posedge CLK) begin
    if (mem_rd.en)
      rd_word <= mem[mem_rd.addr];
  end

  always_ff @(posedge CLK) begin
    if (!RST)
      rd_pend <= 1'b0;
    else
      rd_pend <= mem_rd.en;
  end

  // output holds until the next accepted pop lands
  always_ff @(posedge CLK) begin
    if (!RST)
      rd_data <= '0;
    else if (rd_pend)
      rd_data <= rd_word;
  end

endmodule

// File: verilog/lsab_top.sv
`timescale 1ns/1ps
`include "lsab_defines.svh"

module lsab_top
  import lsab_queue_pkg::*,
         lsab_mem_pkg::*;
(
  input  logic           CLK,
  input  logic           RST,
  input  lsab_req_t      wr_req,
  input  lsab_word_vec_t wr_data,
  input  lsab_req_t      rd_req,
  output lsab_word_t     rd_data,
  output lsab_qmask_t    empty
);

  lsab_qmask_t  push;
  lsab_qmask_t  pop;
  lsab_qstate_t qstate [`LSAB_NUM_QUEUES];
  lsab_mem_wr_t mem_wr;
  lsab_mem_rd_t mem_rd;

  genvar q;
  generate
    for (q = 0; q < `LSAB_NUM_QUEUES; q++) begin : g_queue
      lsab_queue_ctrl lsab_queue_ctrl_i (
        .CLK   (CLK),
        .RST   (RST),
        .push  (push[q]),
        .pop   (pop[q]),
        .state (qstate[q])
      );

      assign empty[q] = qstate[q].empty;
    end
  endgenerate

  lsab_port_mux lsab_port_mux_i (
    .wr_req  (wr_req),
    .rd_req  (rd_req),
    .wr_data (wr_data),
    .qstate  (qstate),
    .push    (push),
    .pop     (pop),
    .mem_wr  (mem_wr),
    .mem_rd  (mem_rd)
  );

  // one shared RAM, 64-word region per queue
  lsab_sram lsab_sram_i (
    .CLK     (CLK),
    .RST     (RST),
    .mem_wr  (mem_wr),
    .mem_rd  (mem_rd),
    .rd_data (rd_data)
  );

endmodule

// File: testbench/lsab_tb_model.svh
`ifndef LSAB_TB_MODEL_SVH
`define LSAB_TB_MODEL_SVH

// four bounded FIFOs, stepped once per rising edge of the DUT

typedef struct packed {
  lsab_word_t  rd_data;
  lsab_qmask_t empty;
} exp_out_t;

lsab_word_t model_q [`LSAB_NUM_QUEUES][$];
lsab_word_t model_rd_data;   // what rd_data holds now
lsab_word_t model_pend_word; // popped at the last edge, lands at the next
logic       model_pend;
int         model_pops;

function automatic void model_reset();
  for (int q = 0; q < `LSAB_NUM_QUEUES; q++)
    model_q[q].delete();
  model_rd_data   = '0;
  model_pend_word = '0;
  model_pend      = 1'b0;
endfunction

// inputs are the values the DUT samples at the coming edge
function automatic void model_step(input lsab_req_t w, input lsab_word_vec_t d,
                                   input lsab_req_t r);
  logic wr_ok;
  logic rd_ok;
  wr_ok = w.valid && (model_q[w.qsel].size() < `LSAB_QUEUE_MAX); // full drops
  rd_ok = r.valid && (model_q[r.qsel].size() > 0); // empty ignores, even with a push
  if (model_pend)
    model_rd_data = model_pend_word;
  model_pend = rd_ok;
  if (rd_ok) begin
    model_pend_word = model_q[r.qsel].pop_front();
    model_pops++;
  end
  if (wr_ok)
    model_q[w.qsel].push_back(d[w.qsel]);
endfunction

function automatic exp_out_t expected_outputs();
  exp_out_t e;
  e.rd_data = model_rd_data;
  for (int q = 0; q < `LSAB_NUM_QUEUES; q++)
    e.empty[q] = (model_q[q].size() == 0);
  return e;
endfunction

`endif

// File: testbench/lsab_tb.sv
`timescale 1ns/1ps
`include "lsab_defines.svh"

module lsab_tb
  import lsab_queue_pkg::*;
();

  localparam int WAIT_LIMIT = 200;

  logic           CLK;
  logic           RST;
  lsab_req_t      wr_req;
  lsab_word_vec_t wr_data;
  lsab_req_t      rd_req;
  lsab_word_t     rd_data;
  lsab_qmask_t    empty;

  int rd_errs;
  int empty_errs;
  int other_errs;

  `include "lsab_tb_model.svh"

  lsab_top lsab_top_i (
    .CLK     (CLK),
    .RST     (RST),
    .wr_req  (wr_req),
    .wr_data (wr_data),
    .rd_req  (rd_req),
    .rd_data (rd_data),
    .empty   (empty)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  function automatic lsab_word_t make_word(input int q, input int i);
    return {4'hc, 4'(q), 8'h5a, 16'(i)};
  endfunction

  function automatic lsab_req_t make_req(input logic valid, input int q);
    lsab_req_t r;
    r.valid = valid;
    r.qsel  = lsab_qsel_t'(q);
    return r;
  endfunction

  function automatic lsab_word_vec_t lane_vec(input int q, input lsab_word_t word);
    lsab_word_vec_t v;
    for (int l = 0; l < `LSAB_NUM_QUEUES; l++)
      v[l] = ~word ^ lsab_word_t'(l); // decoys on the other lanes
    v[q] = word;
    return v;
  endfunction

  task automatic drive(input lsab_req_t w, input lsab_word_vec_t d, input lsab_req_t r);
    @(posedge CLK);
    wr_req  <= w;
    wr_data <= d;
    rd_req  <= r;
  endtask

  task automatic idle(input int n);
    repeat (n) drive('0, '0, '0);
  endtask

  task automatic push_word(input int q, input lsab_word_t word);
    drive(make_req(1'b1, q), lane_vec(q, word), '0);
  endtask

  task automatic pop_word(input int q);
    drive('0, '0, make_req(1'b1, q));
  endtask

  task automatic push_pop(input int qw, input lsab_word_t word, input int qr);
    drive(make_req(1'b1, qw), lane_vec(qw, word), make_req(1'b1, qr));
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      other_errs++;
      $display("ERROR %s: expected %0h, got %0h at %0t", name, want, got, $time);
    end
  endtask

  task automatic finish_run();
    int total;
    total = rd_errs + empty_errs + other_errs;
    $display("errors: rd_data %0d, empty %0d, direct %0d (pops modeled %0d)",
             rd_errs, empty_errs, other_errs, model_pops);
    if (total == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  endtask

  // sampled on falling edges between the DUT's rising edges
  task automatic wait_empty(input lsab_qmask_t mask);
    int n;
    n = 0;
    @(negedge CLK);
    while (((empty & mask) != mask) && (n < WAIT_LIMIT)) begin
      @(negedge CLK);
      n++;
    end
    if ((empty & mask) != mask) begin
      other_errs++;
      $display("timeout: queues %0h did not drain within %0d cycles", mask, WAIT_LIMIT);
      finish_run();
    end
  endtask

  initial begin : compare_outputs
    exp_out_t want;
    forever begin
      @(negedge CLK);
      if (RST !== 1'b1) begin
        model_reset(); // next edge is a reset edge
      end else begin
        want = expected_outputs();
        assert (rd_data === want.rd_data) else begin
          rd_errs++;
          $display("ERROR rd_data: expected %h, got %h at %0t", want.rd_data, rd_data, $time);
        end
        assert (empty === want.empty) else begin
          empty_errs++;
          $display("ERROR empty: expected %h, got %h at %0t", want.empty, empty, $time);
        end
        model_step(wr_req, wr_data, rd_req);
      end
    end
  end

  initial begin : stimulus
    lsab_req_t      w;
    lsab_req_t      r;
    lsab_word_vec_t d;
    int             wr_pct;
    rd_errs    = 0;
    empty_errs = 0;
    other_errs = 0;
    model_pops = 0;
    RST        = 1'b0;
    wr_req     = '0;
    wr_data    = '0;
    rd_req     = '0;
    void'($urandom(32'hc176));

    repeat (2) @(posedge CLK);
    RST <= 1'b1;

    // reads of empty queues right after reset do nothing
    @(negedge CLK);
    check_value("empty", empty, 32'hf);
    check_value("rd_data", rd_data, 32'h0);
    for (int q = 0; q < `LSAB_NUM_QUEUES; q++)
      pop_word(q);
    idle(3);
    @(negedge CLK);
    check_value("rd_data", rd_data, 32'h0);

    // each queue through its own lane and read back interleaved
    for (int i = 0; i < 6; i++)
      for (int q = 0; q < `LSAB_NUM_QUEUES; q++)
        push_word(q, make_word(q, i));
    for (int i = 0; i < 6; i++)
      for (int q = 0; q < `LSAB_NUM_QUEUES; q++)
        pop_word(q);
    idle(1);
    wait_empty(4'hf);

    // overfill one queue
    for (int i = 0; i < 70; i++)
      push_word(2, make_word(2, i)); // last 7 are dropped
    for (int i = 0; i < 63; i++)
      pop_word(2);
    idle(1);
    wait_empty(4'b0100);
    idle(2);
    @(negedge CLK);
    check_value("rd_data", rd_data, make_word(2, 62));
    pop_word(2);
    idle(3);
    @(negedge CLK);
    check_value("rd_data", rd_data, make_word(2, 62));

    // push and pop together on a non-empty queue
    for (int i = 0; i < 3; i++)
      push_word(1, make_word(1, i));
    for (int i = 3; i < 8; i++)
      push_pop(1, make_word(1, i), 1);
    pop_word(1);
    pop_word(1);
    idle(1);
    @(negedge CLK);
    check_value("empty[1]", empty[1], 32'h0); // one entry left
    pop_word(1);
    idle(1);
    @(negedge CLK);
    check_value("empty[1]", empty[1], 32'h1);

    // on an empty queue only the push counts
    push_pop(0, make_word(0, 40), 0);
    idle(1);
    @(negedge CLK);
    check_value("empty[0]", empty[0], 32'h0);
    check_value("rd_data", rd_data, make_word(1, 7));
    pop_word(0);
    idle(2);
    @(negedge CLK);
    check_value("rd_data", rd_data, make_word(0, 40));

    // back-to-back reads alternating between two queues
    for (int i = 0; i < 4; i++) begin
      push_word(0, make_word(0, 50 + i));
      push_word(3, make_word(3, 50 + i));
    end
    for (int i = 0; i < 8; i++)
      pop_word((i % 2 == 1) ? 3 : 0);
    idle(1);
    wait_empty(4'b1001);

    // write-heavy first half so queues tend to fill up
    for (int i = 0; i < 2000; i++) begin
      wr_pct = (i < 1000) ? 60 : 35;
      w = make_req(($urandom % 100) < wr_pct, int'($urandom % 4));
      r = make_req(($urandom % 100) < 45, int'($urandom % 4));
      for (int l = 0; l < `LSAB_NUM_QUEUES; l++)
        d[l] = $urandom;
      drive(w, d, r);
    end
    idle(3);
    @(negedge CLK);
    finish_run();
  end

endmodule

// File: build.f
+incdir+verilog
+incdir+testbench
verilog/lsab_queue_pkg.sv
verilog/lsab_mem_pkg.sv
verilog/lsab_queue_ctrl.sv
verilog/lsab_port_mux.sv
verilog/lsab_sram.sv
verilog/lsab_top.sv
testbench/lsab_tb.sv

// File: Bender.yml
package:
  name: lsab

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lsab_queue_pkg.sv
      - verilog/lsab_mem_pkg.sv
      - verilog/lsab_queue_ctrl.sv
      - verilog/lsab_port_mux.sv
      - verilog/lsab_sram.sv
      - verilog/lsab_top.sv

  - target: test
    include_dirs:
      - verilog
      - testbench
    files:
      - testbench/lsab_tb.sv
